// File: source/xb_pkg.sv
/*
 * Shared sizes, settings map and index types for the packet crossbar.
 * Every crossbar module pulls these in with a wildcard import.
 */

package xb_pkg;

  // ############################
  // stream and port sizing
  // ############################
  localparam int XB_NUM_PORTS    = 4;   // inputs, and also outputs.
  localparam int XB_DATA_W       = 64;  // stream data width.
  localparam int XB_DST_W        = 16;  // destination field in the header.
  localparam int XB_LOCAL_ADDR_W = 8;   // upper byte of the destination.

  // ############################
  // route table and settings map
  // ############################
  localparam int XB_LOCAL_ENTRIES = 16;
  localparam int XB_LOCAL_IDX_W   = $clog2(XB_LOCAL_ENTRIES);
  localparam int XB_SET_BASE      = 0;                             // local entry 0.
  localparam int XB_SET_REMOTE    = XB_SET_BASE + XB_LOCAL_ENTRIES; // remote entry.
  localparam int XB_SET_AW        = 16;
  localparam int XB_SET_DW        = 32;

  // readback of the per-output packet counters
  localparam int XB_CNT_W  = 32;
  localparam int XB_RB_AW  = 3;

  // an output port number.
  typedef logic [$clog2(XB_NUM_PORTS)-1:0] port_idx_t;

  // the routed destination field, low bits of the header beat.
  typedef logic [XB_DST_W-1:0] dst_t;

endpackage

// File: source/axis_if.sv
/*
 * Stream bundle used between crossbar blocks. The master drives data,
 * last and valid, the slave answers with ready.
 */

`timescale 1ns/1ns

interface axis_if import xb_pkg::*; ();

  logic [XB_DATA_W-1:0] tdata;
  logic                 tlast;
  logic                 tvalid;
  logic                 tready;  // beat moves when valid and ready are both high.

  modport master (
    output tdata, tlast, tvalid,
    input  tready
  );

  modport slave (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface

// File: source/xb_regs.sv
/*
 * Route table behind the settings bus, with a combinational lookup per input,
 * plus one packet counter per output that the readback bus returns.
 */

`timescale 1ns/1ns

module xb_regs import xb_pkg::*; (
  input  logic                       clk,
  input  logic                       i_rst,
  input  logic                       i_clear,
  input  logic [XB_LOCAL_ADDR_W-1:0] i_local_addr,
  input  logic                       i_set_stb,
  input  logic [XB_SET_AW-1:0]       i_set_addr,
  input  logic [XB_SET_DW-1:0]       i_set_data,
  input  logic                       i_rb_stb,
  input  logic [XB_RB_AW-1:0]        i_rb_addr,
  input  dst_t                       i_lookup_dst [XB_NUM_PORTS],
  input  logic [XB_NUM_PORTS-1:0]    i_pkt_done,
  output port_idx_t                  o_lookup_port [XB_NUM_PORTS],
  output logic [XB_CNT_W-1:0]        o_rb_data
);

  port_idx_t            local_tbl [XB_LOCAL_ENTRIES];
  port_idx_t            remote_q;
  logic [XB_SET_AW-1:0] set_off;  // address relative to the table base.
  logic [XB_CNT_W-1:0]  pkt_cnt [XB_NUM_PORTS];

  assign set_off = i_set_addr - XB_SET_AW'(XB_SET_BASE);

  // ############################
  // table writes
  // ############################
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int k = 0; k < XB_LOCAL_ENTRIES; k++) begin
        local_tbl[k] <= port_idx_t'(k);  // entry k goes to output k mod 4.
      end
      remote_q <= '0;
    end else if (i_set_stb) begin
      if (set_off < XB_SET_AW'(XB_LOCAL_ENTRIES)) begin
        local_tbl[set_off[XB_LOCAL_IDX_W-1:0]] <= i_set_data[1:0];
      end else if (set_off == XB_SET_AW'(XB_LOCAL_ENTRIES)) begin
        remote_q <= i_set_data[1:0];
      end
      // anything else falls outside the map and is dropped.
    end
  end

  // lookup, answered in the same cycle.
  always_comb begin
    for (int i = 0; i < XB_NUM_PORTS; i++) begin
      if (i_lookup_dst[i][XB_DST_W-1 -: XB_LOCAL_ADDR_W] == i_local_addr) begin
        o_lookup_port[i] = local_tbl[i_lookup_dst[i][XB_LOCAL_IDX_W-1:0]];
      end else begin
        o_lookup_port[i] = remote_q;
      end
    end
  end

  // ############################
  // counters and readback
  // ############################
  always_ff @(posedge clk) begin
    for (int o = 0; o < XB_NUM_PORTS; o++) begin
      if (i_rst || i_clear) begin
        pkt_cnt[o] <= '0;
      end else if (i_pkt_done[o]) begin
        pkt_cnt[o] <= pkt_cnt[o] + 1'b1;  // one per delivered tlast.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_rb_data <= '0;
    end else if (i_rb_stb) begin
      if (i_rb_addr < XB_RB_AW'(XB_NUM_PORTS)) begin
        o_rb_data <= pkt_cnt[port_idx_t'(i_rb_addr)];
      end else begin
        o_rb_data <= '0;  // upper half of the space reads empty.
      end
    end
  end

  a_set_addr_known : assert property (@(posedge clk) disable iff (i_rst)
    i_set_stb |-> !$isunknown(i_set_addr));

endmodule

// File: source/xb_input_dispatch.sv
/*
 * Per-input front end. Catches the header beat, latches the routed output and
 * holds a request to that output until the packet's tlast has gone through.
 */

`timescale 1ns/1ns

module xb_input_dispatch import xb_pkg::*; (
  input  logic                    clk,
  input  logic                    i_rst,
  axis_if.slave                   s_in,
  input  port_idx_t               i_route,
  input  logic [XB_NUM_PORTS-1:0] i_grant,
  input  logic [XB_NUM_PORTS-1:0] i_out_ready,
  output dst_t                    o_dst,
  output logic [XB_NUM_PORTS-1:0] o_req
);

  typedef enum logic [1:0] {
    ST_IDLE,  // waiting for a header beat.
    ST_REQ,   // request up, no grant seen yet.
    ST_FWD    // granted, beats flowing.
  } state_t;

  state_t    state_q;
  port_idx_t route_q;  // output chosen for the open packet.
  logic      xfer;

  assign o_dst = s_in.tdata[XB_DST_W-1:0];  // only meaningful on the header.

  // only the granted output can be ready for us.
  assign s_in.tready = (state_q != ST_IDLE) && |(i_grant & i_out_ready);
  assign xfer        = s_in.tvalid && s_in.tready;

  assign o_req = (state_q == ST_IDLE) ? '0 : (XB_NUM_PORTS'(1) << route_q);

  // ############################
  // packet FSM
  // ############################
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (s_in.tvalid) begin
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (xfer && s_in.tlast) begin
            state_q <= ST_IDLE;  // single-beat packet.
          end else if (i_grant[route_q]) begin
            state_q <= ST_FWD;
          end
        end
        ST_FWD: begin
          if (xfer && s_in.tlast) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // route is latched from the header while idle.
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && s_in.tvalid) begin
      route_q <= i_route;
    end
  end

  a_req_onehot : assert property (@(posedge clk) disable iff (i_rst)
    $onehot0(o_req));

  // the arbiter must keep us granted until our tlast has moved.
  a_grant_held : assert property (@(posedge clk) disable iff (i_rst)
    (state_q == ST_FWD) |-> i_grant[route_q]);

endmodule

// File: source/xb_output_arbiter.sv
/*
 * Per-output arbiter. Picks one requesting input round-robin, keeps it until
 * the packet's tlast moves, and muxes that input onto the output stream.
 */

`timescale 1ns/1ns

module xb_output_arbiter import xb_pkg::*; (
  input  logic                    clk,
  input  logic                    i_rst,
  input  logic [XB_NUM_PORTS-1:0] i_req,
  axis_if.slave                   s_in [XB_NUM_PORTS],
  output logic [XB_NUM_PORTS-1:0] o_grant,
  axis_if.master                  m_out,
  output logic                    o_pkt_done
);

  logic [XB_DATA_W-1:0]    in_data [XB_NUM_PORTS];
  logic [XB_NUM_PORTS-1:0] in_valid;
  logic [XB_NUM_PORTS-1:0] in_last;

  logic                    lock_q;   // a packet is open on this output.
  logic [XB_NUM_PORTS-1:0] grant_q;
  port_idx_t               last_q;   // last granted, also the mux select.
  port_idx_t               next_idx;
  port_idx_t               cand;
  logic                    found;
  logic                    eop;

  // tap the fanned-in streams, ready is driven by each input's dispatch.
  for (genvar g = 0; g < XB_NUM_PORTS; g++) begin : g_tap
    assign in_data[g]  = s_in[g].tdata;
    assign in_valid[g] = s_in[g].tvalid;
    assign in_last[g]  = s_in[g].tlast;
  end

  // ############################
  // round-robin search
  // ############################
  always_comb begin
    next_idx = last_q;
    found    = 1'b0;
    cand     = last_q;
    for (int k = 1; k <= XB_NUM_PORTS; k++) begin
      cand = port_idx_t'(last_q + k);  // start just past the last winner.
      if (!found && i_req[cand]) begin
        next_idx = cand;
        found    = 1'b1;
      end
    end
  end

  // ############################
  // grant and packet lock
  // ############################
  always_ff @(posedge clk) begin
    if (i_rst) begin
      lock_q  <= 1'b0;
      grant_q <= '0;
      last_q  <= port_idx_t'(XB_NUM_PORTS - 1);  // first search starts at 0.
    end else if (!lock_q) begin
      if (found) begin
        lock_q  <= 1'b1;
        grant_q <= XB_NUM_PORTS'(1) << next_idx;
        last_q  <= next_idx;
      end
    end else if (eop) begin
      lock_q  <= 1'b0;  // free again after the tlast beat.
      grant_q <= '0;
    end
  end

  assign o_grant = grant_q;

  // data mux, no register in the path.
  assign m_out.tdata  = in_data[last_q];
  assign m_out.tlast  = in_last[last_q];
  assign m_out.tvalid = lock_q && in_valid[last_q];

  assign eop        = m_out.tvalid && m_out.tready && m_out.tlast;
  assign o_pkt_done = eop;

  a_grant_onehot : assert property (@(posedge clk) disable iff (i_rst)
    $onehot0(grant_q));

  // no switching inputs in the middle of a packet.
  a_grant_stable : assert property (@(posedge clk) disable iff (i_rst)
    (lock_q && !eop) |=> $stable(grant_q));

endmodule

// File: source/axi_crossbar.sv
/*
 * Crossbar top level with flat stream ports. Input ready is an output here
 * and output ready an input, matching the wrapper the rest of the system uses.
 */

`timescale 1ns/1ns

module axi_crossbar import xb_pkg::*; (
  input  logic                              clk,
  input  logic                              i_rst,
  input  logic                              i_clear,
  input  logic [XB_LOCAL_ADDR_W-1:0]        i_local_addr,
  input  logic [XB_NUM_PORTS*XB_DATA_W-1:0] i_tdata,
  input  logic [XB_NUM_PORTS-1:0]           i_tvalid,
  input  logic [XB_NUM_PORTS-1:0]           i_tlast,
  output logic [XB_NUM_PORTS-1:0]           i_tready,
  output logic [XB_NUM_PORTS*XB_DATA_W-1:0] o_tdata,
  output logic [XB_NUM_PORTS-1:0]           o_tvalid,
  output logic [XB_NUM_PORTS-1:0]           o_tlast,
  input  logic [XB_NUM_PORTS-1:0]           o_tready,
  input  logic                              i_set_stb,
  input  logic [XB_SET_AW-1:0]              i_set_addr,
  input  logic [XB_SET_DW-1:0]              i_set_data,
  input  logic                              i_rb_stb,
  input  logic [XB_RB_AW-1:0]               i_rb_addr,
  output logic [XB_CNT_W-1:0]               o_rb_data
);

  axis_if in_if  [XB_NUM_PORTS] ();
  axis_if out_if [XB_NUM_PORTS] ();

  dst_t                    lookup_dst  [XB_NUM_PORTS];
  port_idx_t               lookup_port [XB_NUM_PORTS];
  logic [XB_NUM_PORTS-1:0] req_by_in   [XB_NUM_PORTS];  // [input][output].
  logic [XB_NUM_PORTS-1:0] req_by_out  [XB_NUM_PORTS];  // [output][input].
  logic [XB_NUM_PORTS-1:0] gnt_by_out  [XB_NUM_PORTS];
  logic [XB_NUM_PORTS-1:0] gnt_by_in   [XB_NUM_PORTS];
  logic [XB_NUM_PORTS-1:0] pkt_done;

  // ############################
  // per-input dispatch
  // ############################
  for (genvar i = 0; i < XB_NUM_PORTS; i++) begin : g_in
    assign in_if[i].tdata  = i_tdata[i*XB_DATA_W +: XB_DATA_W];
    assign in_if[i].tvalid = i_tvalid[i];
    assign in_if[i].tlast  = i_tlast[i];
    assign i_tready[i]     = in_if[i].tready;

    xb_input_dispatch u_dispatch (
      .clk         (clk),
      .i_rst       (i_rst),
      .s_in        (in_if[i]),
      .i_route     (lookup_port[i]),
      .i_grant     (gnt_by_in[i]),
      .i_out_ready (o_tready),
      .o_dst       (lookup_dst[i]),
      .o_req       (req_by_in[i])
    );

    // transpose requests and grants between the two sides.
    for (genvar o = 0; o < XB_NUM_PORTS; o++) begin : g_xpose
      assign req_by_out[o][i] = req_by_in[i][o];
      assign gnt_by_in[i][o]  = gnt_by_out[o][i];
    end
  end

  // ############################
  // per-output arbitration
  // ############################
  for (genvar o = 0; o < XB_NUM_PORTS; o++) begin : g_out
    xb_output_arbiter u_arbiter (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_req      (req_by_out[o]),
      .s_in       (in_if),
      .o_grant    (gnt_by_out[o]),
      .m_out      (out_if[o]),
      .o_pkt_done (pkt_done[o])
    );

    assign o_tdata[o*XB_DATA_W +: XB_DATA_W] = out_if[o].tdata;
    assign o_tvalid[o]                       = out_if[o].tvalid;
    assign o_tlast[o]                        = out_if[o].tlast;
    assign out_if[o].tready                  = o_tready[o];
  end

  xb_regs u_regs (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_clear       (i_clear),
    .i_local_addr  (i_local_addr),
    .i_set_stb     (i_set_stb),
    .i_set_addr    (i_set_addr),
    .i_set_data    (i_set_data),
    .i_rb_stb      (i_rb_stb),
    .i_rb_addr     (i_rb_addr),
    .i_lookup_dst  (lookup_dst),
    .i_pkt_done    (pkt_done),
    .o_lookup_port (lookup_port),
    .o_rb_data     (o_rb_data)
  );

endmodule

// File: tests/tb_axi_crossbar.sv
/*
 * Table-driven regression for the packet crossbar. Each row launches a packet,
 * reprograms the route table or reads and clears the counters. A route model
 * and per-source scoreboard check every delivered beat.
 */

`timescale 1ns/1ns

module tb_axi_crossbar import xb_pkg::*; ();

  localparam int                         RST_CYCLES = 10;
  localparam int                         ROW_CYCLES = 200;
  localparam logic [XB_LOCAL_ADDR_W-1:0] LOCAL_ADDR = 8'h3c;
  localparam logic [1:0]                 CMD_NONE   = 2'd0;
  localparam logic [1:0]                 CMD_READ   = 2'd1;
  localparam logic [1:0]                 CMD_CLEAR  = 2'd2;

  typedef struct packed {
    port_idx_t   src;
    logic [15:0] seq;
    logic [7:0]  len;
    dst_t        dst;
    port_idx_t   port;  // output the route model picked.
  } pkt_t;

  typedef struct packed {
    port_idx_t            src;
    dst_t                 dst;
    logic [7:0]           len;  // zero means no packet in this row.
    logic                 set_en;
    logic [XB_SET_AW-1:0] set_addr;
    port_idx_t            set_port;
    logic                 bp;   // random tready on the outputs.
    logic [1:0]           cmd;
  } row_t;

  logic                              clk = 1'b0;
  logic                              i_rst;
  logic                              i_clear;
  logic [XB_LOCAL_ADDR_W-1:0]        i_local_addr;
  logic [XB_NUM_PORTS*XB_DATA_W-1:0] i_tdata;
  logic [XB_NUM_PORTS-1:0]           i_tvalid;
  logic [XB_NUM_PORTS-1:0]           i_tlast;
  logic [XB_NUM_PORTS-1:0]           i_tready;
  logic [XB_NUM_PORTS*XB_DATA_W-1:0] o_tdata;
  logic [XB_NUM_PORTS-1:0]           o_tvalid;
  logic [XB_NUM_PORTS-1:0]           o_tlast;
  logic [XB_NUM_PORTS-1:0]           o_tready;
  logic                              i_set_stb;
  logic [XB_SET_AW-1:0]              i_set_addr;
  logic [XB_SET_DW-1:0]              i_set_data;
  logic                              i_rb_stb;
  logic [XB_RB_AW-1:0]               i_rb_addr;
  logic [XB_CNT_W-1:0]               o_rb_data;

  row_t                    rows [$];
  pkt_t                    launch_q [XB_NUM_PORTS][$];  // per input, not yet sent.
  pkt_t                    exp_q [XB_NUM_PORTS][$];     // per input, not yet seen out.
  pkt_t                    cur [XB_NUM_PORTS];
  pkt_t                    ocur [XB_NUM_PORTS];
  int                      beat_idx [XB_NUM_PORTS];
  int                      obeat [XB_NUM_PORTS];
  logic [XB_NUM_PORTS-1:0] busy;
  logic [XB_NUM_PORTS-1:0] open_pkt;
  logic [XB_NUM_PORTS-1:0] in_xfer;
  logic [15:0]             seq_ctr [XB_NUM_PORTS];
  port_idx_t               local_model [XB_LOCAL_ENTRIES];
  port_idx_t               remote_model;
  logic [XB_CNT_W-1:0]     cnt_model [XB_NUM_PORTS];
  logic                    bp_en;
  logic                    table_ready;

  axi_crossbar i_dut (.*);

  always #4 clk = ~clk;

  // ##############################
  // model and checks
  // ##############################
  function automatic port_idx_t expected_port(dst_t d);
    if (d[XB_DST_W-1 -: XB_LOCAL_ADDR_W] == LOCAL_ADDR) begin
      return local_model[d[XB_LOCAL_IDX_W-1:0]];
    end
    return remote_model;
  endfunction

  // source tag on top, header carries the destination in its low bits.
  function automatic logic [XB_DATA_W-1:0] beat_word(pkt_t p, int beat);
    if (beat == 0) begin
      return {8'(p.src), p.seq, 16'h0000, 8'ha5, p.dst};
    end
    return {8'(p.src), p.seq, 16'(beat), 8'h5a, ~p.dst};
  endfunction

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_port(string name, port_idx_t exp, port_idx_t act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_beat(string name, logic [XB_DATA_W-1:0] exp, logic [XB_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(string name, logic [XB_CNT_W-1:0] exp, logic [XB_CNT_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ##############################
  // stream drivers and monitor
  // ##############################
  always @(posedge clk) begin
    for (int o = 0; o < XB_NUM_PORTS; o++) begin
      o_tready[o] <= (bp_en && !i_rst) ? 1'($urandom) : 1'b1;
    end
  end

  always @(posedge clk) begin
    if (i_rst) begin
      busy = '0;
      i_tvalid <= '0;
      i_tlast  <= '0;
    end else begin
      for (int s = 0; s < XB_NUM_PORTS; s++) begin
        if (in_xfer[s]) begin
          if (beat_idx[s] == int'(cur[s].len) - 1) begin
            busy[s] = 1'b0;  // tlast went through.
          end else begin
            beat_idx[s]++;
          end
        end
        if (!busy[s] && launch_q[s].size() > 0) begin
          cur[s] = launch_q[s].pop_front();
          busy[s] = 1'b1;
          beat_idx[s] = 0;
        end
        i_tvalid[s] <= busy[s];
        i_tlast[s]  <= busy[s] && (beat_idx[s] == int'(cur[s].len) - 1);
        if (busy[s]) begin
          i_tdata[s*XB_DATA_W +: XB_DATA_W] <= beat_word(cur[s], beat_idx[s]);
        end
      end
    end
  end

  // sampled mid-cycle: these beats move on the next rising edge.
  always @(negedge clk) begin : monitor
    int                   tag;
    logic [XB_DATA_W-1:0] word;
    in_xfer <= i_rst ? '0 : (i_tvalid & i_tready);
    for (int o = 0; o < XB_NUM_PORTS && !i_rst; o++) begin
      if (o_tvalid[o] && o_tready[o]) begin
        word = o_tdata[o*XB_DATA_W +: XB_DATA_W];
        if (!open_pkt[o]) begin
          tag = int'(word[XB_DATA_W-1 -: 8]);
          if (tag >= XB_NUM_PORTS || exp_q[tag].size() == 0) begin
            $display("output %0d carried a packet from input %0d that was never sent", o, tag);
            abort_run();
          end
          ocur[o] = exp_q[tag].pop_front();  // oldest open packet of that source.
          check_port($sformatf("route of input %0d", tag), ocur[o].port, port_idx_t'(o));
          open_pkt[o] = 1'b1;
          obeat[o] = 0;
        end
        check_beat($sformatf("o_tdata[%0d]", o), beat_word(ocur[o], obeat[o]), word);
        check_flag($sformatf("o_tlast[%0d]", o), obeat[o] == int'(ocur[o].len) - 1, o_tlast[o]);
        if (o_tlast[o]) begin
          open_pkt[o] = 1'b0;
        end else begin
          obeat[o]++;
        end
      end
    end
  end

  // ##############################
  // row actions
  // ##############################
  function automatic logic all_drained();
    for (int s = 0; s < XB_NUM_PORTS; s++) begin
      if (launch_q[s].size() != 0 || exp_q[s].size() != 0 || busy[s] || open_pkt[s]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic wait_drain();
    do begin
      @(negedge clk);
    end while (!all_drained());
    repeat (3) @(negedge clk);
  endtask

  task automatic write_setting(logic [XB_SET_AW-1:0] addr, port_idx_t port);
    int off;
    off = int'(addr) - XB_SET_BASE;
    @(posedge clk);
    i_set_stb  <= 1'b1;
    i_set_addr <= addr;
    i_set_data <= XB_SET_DW'(port);
    @(posedge clk);
    i_set_stb <= 1'b0;
    if (off >= 0 && off < XB_LOCAL_ENTRIES) begin
      local_model[off[XB_LOCAL_IDX_W-1:0]] = port;
    end else if (off == XB_LOCAL_ENTRIES) begin
      remote_model = port;
    end
  endtask

  task automatic read_counters();
    logic [XB_CNT_W-1:0] exp_cnt;
    for (int a = 0; a <= XB_NUM_PORTS; a++) begin
      exp_cnt = '0;  // addresses past the last output read as zero.
      if (a < XB_NUM_PORTS) begin
        exp_cnt = cnt_model[a];
      end
      @(posedge clk);
      i_rb_stb  <= 1'b1;
      i_rb_addr <= XB_RB_AW'(a);
      @(posedge clk);
      i_rb_stb <= 1'b0;
      @(negedge clk);
      check_count($sformatf("o_rb_data[%0d]", a), exp_cnt, o_rb_data);
    end
  endtask

  task automatic clear_counters();
    @(posedge clk);
    i_clear <= 1'b1;
    @(posedge clk);
    i_clear <= 1'b0;
    for (int o = 0; o < XB_NUM_PORTS; o++) begin
      cnt_model[o] = '0;
    end
  endtask

  task automatic launch(row_t r);
    pkt_t p;
    p.src  = r.src;
    p.seq  = seq_ctr[r.src];
    p.len  = r.len;
    p.dst  = r.dst;
    p.port = expected_port(r.dst);
    seq_ctr[r.src] = seq_ctr[r.src] + 16'd1;
    cnt_model[p.port] = cnt_model[p.port] + 1'b1;  // one more packet due there.
    launch_q[r.src].push_back(p);
    exp_q[r.src].push_back(p);
  endtask

  // table edits and commands wait for the crossbar to go quiet.
  task automatic apply_row(row_t r);
    if (r.set_en || r.cmd != CMD_NONE) begin
      wait_drain();
      if (r.set_en) begin
        write_setting(r.set_addr, r.set_port);
      end
      if (r.cmd == CMD_READ) begin
        read_counters();
      end else if (r.cmd == CMD_CLEAR) begin
        clear_counters();
      end
      @(negedge clk);
    end
    bp_en <= r.bp;
    if (r.len != '0) begin
      launch(r);
    end
  endtask

  // ##############################
  // stimulus table
  // ##############################
  task automatic add_pkt(int src, int dst, int len, logic bp);
    row_t r = '0;
    r.src = port_idx_t'(src);
    r.dst = dst_t'(dst);
    r.len = 8'(len);
    r.bp  = bp;
    rows.push_back(r);
  endtask

  task automatic add_set(int addr, int port);
    row_t r = '0;
    r.set_en   = 1'b1;
    r.set_addr = XB_SET_AW'(addr);
    r.set_port = port_idx_t'(port);
    rows.push_back(r);
  endtask

  task automatic add_cmd(logic [1:0] cmd);
    row_t r = '0;
    r.cmd = cmd;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_pkt(0, 16'h3c00, 3, 1'b0);  // reset routes, entry k to output k mod 4.
    add_pkt(1, 16'h3c01, 2, 1'b0);
    add_pkt(2, 16'h3c02, 4, 1'b0);
    add_pkt(3, 16'h3c03, 1, 1'b0);
    add_pkt(0, 16'h3c07, 2, 1'b0);
    add_pkt(1, 16'h1234, 3, 1'b0);  // remote.
    add_cmd(CMD_READ);
    add_set(XB_SET_BASE + 0, 2);
    add_set(XB_SET_BASE + 5, 3);
    add_set(XB_SET_REMOTE, 1);
    add_set(XB_SET_BASE + 40, 3);  // outside the map.
    add_pkt(0, 16'h3c00, 3, 1'b0);
    add_pkt(3, 16'h3c05, 2, 1'b0);
    add_pkt(2, 16'h5501, 3, 1'b0);
    add_pkt(1, 16'h3c15, 2, 1'b0);
    add_pkt(3, 16'h3c08, 2, 1'b0);  // entry 8 keeps its reset route.
    add_pkt(0, 16'h3c02, 4, 1'b0);  // three inputs onto output 2.
    add_pkt(1, 16'h3c02, 5, 1'b0);
    add_pkt(2, 16'h3c00, 3, 1'b0);
    add_pkt(0, 16'h3c06, 2, 1'b0);
    add_pkt(3, 16'h3c0a, 1, 1'b0);
    add_pkt(1, 16'h3c02, 2, 1'b0);
    add_cmd(CMD_READ);
    add_pkt(0, 16'h3c01, 7, 1'b1);  // random back-pressure.
    add_pkt(1, 16'h3c03, 6, 1'b1);
    add_pkt(2, 16'h3c01, 5, 1'b1);
    add_pkt(3, 16'h9900, 8, 1'b1);
    add_pkt(0, 16'h3c05, 4, 1'b1);
    add_pkt(2, 16'h3c04, 6, 1'b1);
    add_cmd(CMD_READ);
    add_cmd(CMD_CLEAR);
    add_cmd(CMD_READ);
    add_pkt(1, 16'h3c03, 2, 1'b0);
    add_pkt(2, 16'h3c07, 3, 1'b1);
    add_cmd(CMD_READ);
  endtask

  // ##############################
  // run control
  // ##############################
  initial begin : watchdog
    wait (table_ready);
    repeat (RST_CYCLES + ROW_CYCLES * rows.size()) @(posedge clk);
    $display("timeout: packets stopped moving before the table was done");
    abort_run();
  end

  initial begin : main
    void'($urandom(46));
    i_rst        = 1'b1;
    i_clear      = 1'b0;
    i_local_addr = LOCAL_ADDR;
    i_tdata      = '0;
    i_tvalid     = '0;
    i_tlast      = '0;
    o_tready     = '1;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_rb_stb     = 1'b0;
    i_rb_addr    = '0;
    busy         = '0;
    open_pkt     = '0;
    in_xfer      = '0;
    bp_en        = 1'b0;
    table_ready  = 1'b0;
    remote_model = '0;
    for (int k = 0; k < XB_LOCAL_ENTRIES; k++) begin
      local_model[k] = port_idx_t'(k);
    end
    for (int s = 0; s < XB_NUM_PORTS; s++) begin
      seq_ctr[s]   = '0;
      cnt_model[s] = '0;
      beat_idx[s]  = 0;
      obeat[s]     = 0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    i_rst <= 1'b0;
    @(negedge clk);
    foreach (rows[n]) begin
      apply_row(rows[n]);
    end
    wait_drain();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: files.f
source/xb_pkg.sv
source/axis_if.sv
source/xb_regs.sv
source/xb_input_dispatch.sv
source/xb_output_arbiter.sv
source/axi_crossbar.sv
tests/tb_axi_crossbar.sv

// File: Makefile
# Verilator flow for the packet crossbar regression.

TOP := tb_axi_crossbar

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
